// File: verilog/pipibibs_pkg.sv
package pipibibs_pkg;

    // one 68000 bus cycle as seen by the glue logic
    typedef struct packed {
        logic        valid;  // address strobe
        logic        rw;     // 1 = read
        logic [23:1] addr;   // word address
        logic [15:0] wdata;
        logic [1:0]  be;     // {upper, lower} byte enables
    } bus_req_t;

    typedef struct packed {
        logic        dtack;  // one cycle pulse
        logic [15:0] rdata;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        DEV_NONE,
        DEV_ROM,
        DEV_WRAM,
        DEV_PALRAM,
        DEV_SRAM,
        DEV_GCU,
        DEV_IO
    } dev_sel_t;

    // order matters, the GCU model reports the index
    typedef enum logic [2:0] {
        GCU_IDLE,
        GCU_SET_RAM_PTR,
        GCU_SELECT_REG,
        GCU_WRITE_REG,
        GCU_WRITE_RAM,
        GCU_READ_RAM_H,
        GCU_READ_RAM_L
    } gcu_op_t;

    typedef struct packed {
        logic [9:0] joy1;
        logic [9:0] joy2;
        logic [3:0] start;
        logic [3:0] coin;
        logic       service;
        logic       test;
        logic [7:0] dsw_a;
        logic [7:0] dsw_b;
        logic [7:0] dsw_c;
    } cabinet_t;

    // byte addresses of the main CPU map
    localparam logic [23:0] ROM_LAST    = 24'h03FFFF;
    localparam logic [23:0] WRAM_BASE   = 24'h080000; // bits 23:16
    localparam logic [23:0] PALRAM_BASE = 24'h0C0000; // bits 23:12
    localparam logic [23:0] GCU_BASE    = 24'h140000; // bits 23:16
    localparam logic [23:0] SRAM_BASE   = 24'h190000; // bits 23:12
    localparam logic [23:0] IO_BASE     = 24'h19C000; // bits 23:12

    localparam logic [11:0] IO_DSWA   = 12'h020;
    localparam logic [11:0] IO_DSWB   = 12'h024;
    localparam logic [11:0] IO_JUMPER = 12'h028;
    localparam logic [11:0] IO_SYS    = 12'h02C;
    localparam logic [11:0] IO_IN1    = 12'h030;
    localparam logic [11:0] IO_IN2    = 12'h034;

    localparam logic [3:0] GCU_VCOUNT = 4'hC;

    localparam logic [9:0] V_TOTAL       = 10'd262;
    localparam logic [9:0] V_BLANK_START = 10'd245;

    // GP9001 command for a bus cycle, idle when the offset has none
    function automatic gcu_op_t gcu_decode(input bus_req_t req);
        logic [3:0] off;
        gcu_op_t    op;
        off = {req.addr[3:1], 1'b0};
        op  = GCU_IDLE;
        if (req.rw) begin
            case (off)
                4'h4:    op = GCU_READ_RAM_H;
                4'h6:    op = GCU_READ_RAM_L;
                default: op = GCU_IDLE; // vcount is served locally
            endcase
        end else begin
            case (off)
                4'h0:       op = GCU_SET_RAM_PTR;
                4'h8:       op = GCU_SELECT_REG;
                4'hC:       op = GCU_WRITE_REG;
                4'h4, 4'h6: op = GCU_WRITE_RAM;
                default:    op = GCU_IDLE;
            endcase
        end
        return op;
    endfunction

endpackage

// File: verilog/pipibibs_addr_dec.sv
`timescale 1ns/1ps

module pipibibs_addr_dec (
    input  logic                   clk96,
    input  logic                   reset96,
    input  pipibibs_pkg::bus_req_t cpu_req,
    output pipibibs_pkg::dev_sel_t sel,
    output pipibibs_pkg::bus_req_t req_q
);

    logic [23:0]            byte_addr;
    pipibibs_pkg::dev_sel_t sel_d;

    assign byte_addr = {cpu_req.addr, 1'b0}; // map is written in bytes

    always_comb begin
        sel_d = pipibibs_pkg::DEV_NONE;
        if (cpu_req.valid) begin
            if (byte_addr <= pipibibs_pkg::ROM_LAST)
                sel_d = pipibibs_pkg::DEV_ROM;
            else if (byte_addr[23:16] == pipibibs_pkg::WRAM_BASE[23:16])
                sel_d = pipibibs_pkg::DEV_WRAM;
            else if (byte_addr[23:12] == pipibibs_pkg::PALRAM_BASE[23:12])
                sel_d = pipibibs_pkg::DEV_PALRAM;
            else if (byte_addr[23:16] == pipibibs_pkg::GCU_BASE[23:16])
                sel_d = pipibibs_pkg::DEV_GCU;
            else if (byte_addr[23:12] == pipibibs_pkg::SRAM_BASE[23:12])
                sel_d = pipibibs_pkg::DEV_SRAM;
            else if (byte_addr[23:12] == pipibibs_pkg::IO_BASE[23:12])
                sel_d = pipibibs_pkg::DEV_IO;
        end
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            sel   <= pipibibs_pkg::DEV_NONE;
            req_q <= '0;
        end else begin
            sel   <= sel_d;
            req_q <= cpu_req; // cpu holds fields until dtack
        end
    end

    // cpu keeps the cycle frozen while the strobe is held
    assert property (@(posedge clk96) disable iff (reset96)
        cpu_req.valid && $past(cpu_req.valid) |-> cpu_req == $past(cpu_req));

endmodule

// File: verilog/pipibibs_dpram.sv
`timescale 1ns/1ps

module pipibibs_dpram #(
    parameter int AW = 11,
    parameter int DW = 16
) (
    input  logic                  clk96,
    input  logic [AW-1:0]         a_addr,
    input  logic [DW-1:0]         a_wdata,
    input  logic [DW/8-1:0]       a_we,
    output logic [DW-1:0]         a_rdata,
    input  logic [AW-1:0]         b_addr,
    input  logic [DW-1:0]         b_wdata,
    input  logic [DW/8-1:0]       b_we,
    output logic [DW-1:0]         b_rdata
);

    localparam int NB = DW / 8;

    logic [DW-1:0] mem [0:(2**AW)-1];

    always_ff @(posedge clk96) begin
        for (int i = 0; i < NB; i++) begin
            if (a_we[i])
                mem[a_addr][i*8 +: 8] <= a_wdata[i*8 +: 8];
            if (b_we[i])
                mem[b_addr][i*8 +: 8] <= b_wdata[i*8 +: 8]; // port b wins a clash
        end
        a_rdata <= mem[a_addr];
        b_rdata <= mem[b_addr];
    end

endmodule

// File: verilog/pipibibs_io_ports.sv
`timescale 1ns/1ps

module pipibibs_io_ports (
    input  pipibibs_pkg::bus_req_t req_q,
    input  pipibibs_pkg::cabinet_t cab,
    input  logic [8:0]             v,
    output logic [15:0]            io_rdata,
    output logic [15:0]            vstat_rdata
);

    logic [11:0] offset;
    logic [7:0]  p1_byte;
    logic [7:0]  p2_byte;
    logic [7:0]  sys_byte;
    logic [9:0]  v_sum;
    logic [9:0]  v_wrap;

    // cabinet inputs arrive active high, the board reads them inverted
    function automatic logic [7:0] pad_byte(input logic [9:0] joy);
        pad_byte = {1'b0, ~joy[6], ~joy[5], ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
    endfunction

    assign offset  = {req_q.addr[11:1], 1'b0};
    assign p1_byte = pad_byte(cab.joy1);
    assign p2_byte = pad_byte(cab.joy2);

    assign sys_byte = {1'b0, ~cab.start[1], ~cab.start[0], ~cab.coin[1], ~cab.coin[0],
                       ~cab.test, 1'b0, ~cab.service};

    always_comb begin
        case (offset)
            pipibibs_pkg::IO_IN1:    io_rdata = {2{p1_byte}};
            pipibibs_pkg::IO_IN2:    io_rdata = {2{p2_byte}};
            pipibibs_pkg::IO_SYS:    io_rdata = {cab.dsw_c, sys_byte}; // high byte is dsw c
            pipibibs_pkg::IO_DSWA:   io_rdata = {2{cab.dsw_a}};
            pipibibs_pkg::IO_DSWB:   io_rdata = {2{cab.dsw_b}};
            pipibibs_pkg::IO_JUMPER: io_rdata = {2{4'h0, cab.dsw_c[3:0]}};
            default:                 io_rdata = 16'h0000;
        endcase
    end

    // blanking flag, shifted 15 lines ahead of the raster
    always_comb begin
        v_sum       = {1'b0, v} + 10'd15;
        v_wrap      = v_sum % pipibibs_pkg::V_TOTAL;
        vstat_rdata = {15'd0, v_wrap >= pipibibs_pkg::V_BLANK_START};
    end

endmodule

// File: verilog/pipibibs_gcu_ops.sv
`timescale 1ns/1ps

module pipibibs_gcu_ops (
    input  logic                   clk96,
    input  logic                   reset96,
    input  pipibibs_pkg::dev_sel_t sel,
    input  pipibibs_pkg::bus_req_t req_q,
    input  logic                   gcu_ack,
    input  logic [15:0]            gcu_dout,
    output pipibibs_pkg::gcu_op_t  gcu_op,
    output logic                   gcu_done,
    output logic [15:0]            gcu_rdata
);

    typedef enum logic [1:0] {IDLE, WAIT_ACK, DONE} state_t;

    state_t                state;
    pipibibs_pkg::gcu_op_t op_d;

    assign op_d = pipibibs_pkg::gcu_decode(req_q);

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            state    <= IDLE;
            gcu_op   <= pipibibs_pkg::GCU_IDLE;
            gcu_done <= 1'b0;
        end else begin
            gcu_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (sel == pipibibs_pkg::DEV_GCU && op_d != pipibibs_pkg::GCU_IDLE) begin
                        gcu_op <= op_d;
                        state  <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (gcu_ack) begin
                        gcu_op   <= pipibibs_pkg::GCU_IDLE;
                        gcu_done <= 1'b1;
                        state    <= DONE;
                    end
                end
                DONE: if (sel != pipibibs_pkg::DEV_GCU) state <= IDLE; // wait for strobe drop
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk96) begin
        if (state == WAIT_ACK && gcu_ack)
            gcu_rdata <= gcu_dout; // controller data valid with ack
    end

    // held command still matches the frozen bus cycle
    assert property (@(posedge clk96) disable iff (reset96)
        gcu_op != pipibibs_pkg::GCU_IDLE |-> sel == pipibibs_pkg::DEV_GCU && op_d == gcu_op);

endmodule

// File: verilog/pipibibs_bus_ctrl.sv
`timescale 1ns/1ps

module pipibibs_bus_ctrl (
    input  logic                   clk96,
    input  logic                   reset96,
    input  pipibibs_pkg::dev_sel_t sel,
    input  pipibibs_pkg::bus_req_t req_q,
    input  logic [15:0]            wram_rdata,
    input  logic [15:0]            palram_rdata,
    input  logic [7:0]             sram_rdata,
    input  logic [15:0]            io_rdata,
    input  logic [15:0]            vstat_rdata,
    input  logic                   prg_ok,
    input  logic [15:0]            prg_data,
    input  logic                   gcu_done,
    input  logic [15:0]            gcu_rdata,
    output logic                   prg_cs,
    output pipibibs_pkg::bus_rsp_t cpu_rsp
);

    logic [1:0]  sel_cnt;   // cycles into the current selection
    logic        done;
    logic        rom_seen;
    logic [15:0] rom_q;
    logic        gcu_cmd;
    logic        vcount_rd;
    logic        ready;
    logic [15:0] src_data;

    assign prg_cs    = (sel == pipibibs_pkg::DEV_ROM);
    assign gcu_cmd   = (pipibibs_pkg::gcu_decode(req_q) != pipibibs_pkg::GCU_IDLE);
    assign vcount_rd = req_q.rw && ({req_q.addr[3:1], 1'b0} == pipibibs_pkg::GCU_VCOUNT);

    always_comb begin
        case (sel)
            pipibibs_pkg::DEV_ROM: ready = rom_seen;
            pipibibs_pkg::DEV_GCU: ready = gcu_cmd ? gcu_done : (sel_cnt != 2'd0);
            default:               ready = (sel_cnt != 2'd0); // rams, io, unmapped
        endcase
    end

    always_comb begin
        case (sel)
            pipibibs_pkg::DEV_ROM:    src_data = rom_q;
            pipibibs_pkg::DEV_WRAM:   src_data = wram_rdata;
            pipibibs_pkg::DEV_PALRAM: src_data = palram_rdata;
            pipibibs_pkg::DEV_SRAM:   src_data = {2{sram_rdata}};
            pipibibs_pkg::DEV_IO:     src_data = io_rdata;
            pipibibs_pkg::DEV_GCU:
                src_data = gcu_cmd ? gcu_rdata : (vcount_rd ? vstat_rdata : 16'h0000);
            default:                  src_data = 16'h0000;
        endcase
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            sel_cnt  <= 2'd0;
            done     <= 1'b0;
            rom_seen <= 1'b0;
            cpu_rsp  <= '0;
        end else begin
            cpu_rsp.dtack <= 1'b0;
            cpu_rsp.rdata <= 16'h0000;
            if (!req_q.valid) begin
                sel_cnt  <= 2'd0;
                done     <= 1'b0;
                rom_seen <= 1'b0;
            end else begin
                if (sel_cnt != 2'd3)
                    sel_cnt <= sel_cnt + 2'd1;
                if (prg_cs && prg_ok)
                    rom_seen <= 1'b1;
                if (ready && !done) begin
                    done          <= 1'b1;
                    cpu_rsp.dtack <= 1'b1;
                    cpu_rsp.rdata <= req_q.rw ? src_data : 16'h0000;
                end
            end
        end
    end

    always_ff @(posedge clk96) begin
        if (prg_cs && prg_ok && !rom_seen)
            rom_q <= prg_data;
    end

    // dtack only inside a strobed cycle, unmapped ones included
    assert property (@(posedge clk96) disable iff (reset96)
        cpu_rsp.dtack |-> req_q.valid && $past(req_q.valid));

endmodule

// File: verilog/pipibibs_main.sv
`timescale 1ns/1ps

module pipibibs_main #(
    parameter int WRAM_AW   = 13,
    parameter int PALRAM_AW = 11,
    parameter int SRAM_AW   = 11
) (
    input  logic                   clk96,
    input  logic                   reset96,
    input  pipibibs_pkg::bus_req_t cpu_req,
    output pipibibs_pkg::bus_rsp_t cpu_rsp,
    input  pipibibs_pkg::cabinet_t cab,
    input  logic [8:0]             v,
    output logic                   prg_cs,
    output logic [16:0]            prg_addr,
    input  logic                   prg_ok,
    input  logic [15:0]            prg_data,
    output pipibibs_pkg::gcu_op_t  gcu_op,
    input  logic                   gcu_ack,
    input  logic [15:0]            gcu_dout,
    input  logic [PALRAM_AW-1:0]   palram_addr,
    output logic [15:0]            palram_data,
    input  logic [SRAM_AW-1:0]     sram_addr,
    input  logic [7:0]             sram_din,
    input  logic                   sram_we,
    output logic [7:0]             sram_data
);

    pipibibs_pkg::dev_sel_t sel;
    pipibibs_pkg::bus_req_t req_q;
    logic                   host_wr;
    logic [1:0]             wram_we;
    logic [1:0]             palram_we;
    logic [0:0]             sram_host_we;
    logic [15:0]            wram_rdata;
    logic [15:0]            palram_rdata;
    logic [7:0]             sram_rdata;
    logic [15:0]            io_rdata;
    logic [15:0]            vstat_rdata;
    logic                   gcu_done;
    logic [15:0]            gcu_rdata;

    assign host_wr      = req_q.valid && !req_q.rw;
    assign wram_we      = (host_wr && sel == pipibibs_pkg::DEV_WRAM) ? req_q.be : 2'b00;
    assign palram_we    = (host_wr && sel == pipibibs_pkg::DEV_PALRAM) ? req_q.be : 2'b00;
    assign sram_host_we = host_wr && sel == pipibibs_pkg::DEV_SRAM && req_q.be[0]; // odd byte
    assign prg_addr     = req_q.addr[17:1];

    pipibibs_addr_dec u_addr_dec (
        .clk96(clk96), .reset96(reset96), .cpu_req(cpu_req), .sel(sel), .req_q(req_q)
    );

    pipibibs_dpram #(.AW(WRAM_AW), .DW(16)) u_wram (
        .clk96(clk96),
        .a_addr(req_q.addr[WRAM_AW:1]), .a_wdata(req_q.wdata), .a_we(wram_we),
        .a_rdata(wram_rdata),
        .b_addr('0), .b_wdata(16'h0000), .b_we(2'b00), .b_rdata()
    );

    // second port feeds the video palette lookup
    pipibibs_dpram #(.AW(PALRAM_AW), .DW(16)) u_palram (
        .clk96(clk96),
        .a_addr(req_q.addr[PALRAM_AW:1]), .a_wdata(req_q.wdata), .a_we(palram_we),
        .a_rdata(palram_rdata),
        .b_addr(palram_addr), .b_wdata(16'h0000), .b_we(2'b00), .b_rdata(palram_data)
    );

    pipibibs_dpram #(.AW(SRAM_AW), .DW(8)) u_sram (
        .clk96(clk96),
        .a_addr(req_q.addr[SRAM_AW:1]), .a_wdata(req_q.wdata[7:0]), .a_we(sram_host_we),
        .a_rdata(sram_rdata),
        .b_addr(sram_addr), .b_wdata(sram_din), .b_we(sram_we), .b_rdata(sram_data)
    );

    pipibibs_io_ports u_io_ports (
        .req_q(req_q), .cab(cab), .v(v), .io_rdata(io_rdata), .vstat_rdata(vstat_rdata)
    );

    pipibibs_gcu_ops u_gcu_ops (
        .clk96(clk96), .reset96(reset96), .sel(sel), .req_q(req_q),
        .gcu_ack(gcu_ack), .gcu_dout(gcu_dout),
        .gcu_op(gcu_op), .gcu_done(gcu_done), .gcu_rdata(gcu_rdata)
    );

    pipibibs_bus_ctrl u_bus_ctrl (
        .clk96(clk96), .reset96(reset96), .sel(sel), .req_q(req_q),
        .wram_rdata(wram_rdata), .palram_rdata(palram_rdata), .sram_rdata(sram_rdata),
        .io_rdata(io_rdata), .vstat_rdata(vstat_rdata),
        .prg_ok(prg_ok), .prg_data(prg_data),
        .gcu_done(gcu_done), .gcu_rdata(gcu_rdata),
        .prg_cs(prg_cs), .cpu_rsp(cpu_rsp)
    );

endmodule

// File: verif/pipibibs_tb.sv
`timescale 1ns/1ps

module pipibibs_tb;

    localparam int WRAM_AW    = 13;
    localparam int PALRAM_AW  = 11;
    localparam int SRAM_AW    = 11;
    localparam int OP_CYCLES  = 20;  // watchdog budget per golden line

    logic                   clk96 = 1'b0;
    logic                   reset96;
    pipibibs_pkg::bus_req_t cpu_req;
    pipibibs_pkg::bus_rsp_t cpu_rsp;
    pipibibs_pkg::cabinet_t cab;
    logic [8:0]             v;
    logic                   prg_cs;
    logic [16:0]            prg_addr;
    logic                   prg_ok;
    logic [15:0]            prg_data;
    pipibibs_pkg::gcu_op_t  gcu_op;
    logic                   gcu_ack;
    logic [15:0]            gcu_dout;
    logic [PALRAM_AW-1:0]   palram_addr;
    logic [15:0]            palram_data;
    logic [SRAM_AW-1:0]     sram_addr;
    logic [7:0]             sram_din;
    logic                   sram_we;
    logic [7:0]             sram_data;

    pipibibs_pkg::gcu_op_t  last_op;   // written by the GCU model only
    int                     gcu_cmds;
    int                     rom_reqs;  // prg_cs requests seen by the ROM model
    int                     n_ops = 0;

    // golden file columns
    string       t_name[$];
    string       t_kind[$];
    logic [23:0] t_addr[$];
    logic [15:0] t_data[$];
    logic [1:0]  t_be[$];
    logic [15:0] t_exp[$];
    int          t_op[$];
    int          t_cyc[$];

    pipibibs_main #(
        .WRAM_AW(WRAM_AW), .PALRAM_AW(PALRAM_AW), .SRAM_AW(SRAM_AW)
    ) UUT (
        .clk96(clk96), .reset96(reset96), .cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
        .cab(cab), .v(v),
        .prg_cs(prg_cs), .prg_addr(prg_addr), .prg_ok(prg_ok), .prg_data(prg_data),
        .gcu_op(gcu_op), .gcu_ack(gcu_ack), .gcu_dout(gcu_dout),
        .palram_addr(palram_addr), .palram_data(palram_data),
        .sram_addr(sram_addr), .sram_din(sram_din), .sram_we(sram_we), .sram_data(sram_data)
    );

    always #50 clk96 = ~clk96;  // 100 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_rsp(input string name, input pipibibs_pkg::bus_rsp_t exp,
                             input pipibibs_pkg::bus_rsp_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %0b/%04h actual %0b/%04h",
                                name, exp.dtack, exp.rdata, act.dtack, act.rdata));
    endtask

    task automatic check_op(input string name, input pipibibs_pkg::gcu_op_t exp,
                            input pipibibs_pkg::gcu_op_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %s actual %s",
                                name, exp.name(), act.name()));
    endtask

    task automatic check_data(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %04h actual %04h", name, exp, act));
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("CHECK FAILED %s expected %0d cycles actual %0d cycles",
                                name, exp, act));
    endtask

    task automatic check_rom_cs(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected prg_cs %0b actual %0b",
                                name, exp, act));
    endtask

    // one 68000 cycle, starts and ends 1 ns after a rising edge
    task automatic host_cycle(input logic rw, input logic [23:0] addr,
                              input logic [15:0] wdata, input logic [1:0] be,
                              output pipibibs_pkg::bus_rsp_t rsp, output int cycles);
        cycles        = 0;
        rsp           = '0;
        cpu_req.rw    = rw;
        cpu_req.addr  = addr[23:1];
        cpu_req.wdata = wdata;
        cpu_req.be    = be;
        cpu_req.valid = 1'b1;
        while (!rsp.dtack) begin
            @(posedge clk96);
            #1;
            cycles++;
            rsp = cpu_rsp;
        end
        cpu_req.valid = 1'b0;
        repeat (2) @(posedge clk96);
        #1;
    endtask

    // program ROM with random latency
    initial begin : rom_model
        int unsigned delay;
        prg_ok   = 1'b0;
        prg_data = 16'h0000;
        rom_reqs = 0;
        forever begin
            @(posedge clk96);
            #1;
            if (prg_cs) begin
                rom_reqs = rom_reqs + 1;
                delay = $urandom % 6;
                repeat (delay) @(posedge clk96);
                #1;
                prg_data = ~prg_addr[15:0];
                prg_ok   = 1'b1;
                while (prg_cs) begin
                    @(posedge clk96);
                    #1;
                end
                prg_ok = 1'b0;
            end
        end
    end

    initial begin : gcu_model
        int unsigned delay;
        gcu_ack  = 1'b0;
        gcu_dout = 16'h0000;
        last_op  = pipibibs_pkg::GCU_IDLE;
        gcu_cmds = 0;
        forever begin
            @(posedge clk96);
            #1;
            if (gcu_op != pipibibs_pkg::GCU_IDLE) begin
                last_op  = gcu_op;
                gcu_cmds = gcu_cmds + 1;
                delay    = $urandom % 5;
                repeat (delay) @(posedge clk96);
                #1;
                gcu_dout = 16'hA500 + {13'd0, gcu_op};
                gcu_ack  = 1'b1;
                @(posedge clk96);
                #1;
                gcu_ack = 1'b0; // single cycle ack
            end
        end
    end

    initial begin : watchdog
        wait (n_ops > 0);
        repeat (n_ops * OP_CYCLES + 10) @(posedge clk96);
        abort_run("timeout, a bus cycle never got DTACK");
    end

    initial begin : main_flow
        int                     fd;
        int                     cnt;
        int                     cycles;
        int                     cmds_before;
        int                     roms_before;
        string                  line;
        string                  name;
        string                  kind;
        logic [23:0]            addr;
        logic [15:0]            data;
        logic [1:0]             be;
        logic [15:0]            expv;
        int                     gop;
        int                     cyc;
        pipibibs_pkg::bus_rsp_t rsp;
        pipibibs_pkg::bus_rsp_t exp_rsp;
        pipibibs_pkg::gcu_op_t  seen;

        void'($urandom(67586));
        reset96     = 1'b1;
        cpu_req     = '0;
        v           = 9'd0;
        palram_addr = '0;
        sram_addr   = '0;
        sram_din    = 8'h00;
        sram_we     = 1'b0;
        cab.joy1    = 10'h053;
        cab.joy2    = 10'h000;
        cab.start   = 4'b0001;
        cab.coin    = 4'b0010;
        cab.service = 1'b1;
        cab.test    = 1'b0;
        cab.dsw_a   = 8'h5A;
        cab.dsw_b   = 8'hC3;
        cab.dsw_c   = 8'h96;

        fd = $fopen("verif/pipibibs_golden.txt", "r");
        if (fd == 0)
            abort_run("could not open verif/pipibibs_golden.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%s %s %h %h %h %h %d %d",
                              name, kind, addr, data, be, expv, gop, cyc);
                if (cnt != 8)
                    abort_run($sformatf("golden file line is malformed: %s", line));
                t_name.push_back(name);
                t_kind.push_back(kind);
                t_addr.push_back(addr);
                t_data.push_back(data);
                t_be.push_back(be);
                t_exp.push_back(expv);
                t_op.push_back(gop);
                t_cyc.push_back(cyc);
            end
        end
        $fclose(fd);
        n_ops = t_name.size(); // starts the watchdog

        repeat (2) @(posedge clk96);
        #1;
        reset96 = 1'b0;

        for (int i = 0; i < n_ops; i++) begin
            case (t_kind[i])
                "HR", "HW": begin
                    if (t_kind[i] == "HR")
                        v = t_data[i][8:0]; // raster line for the blanking read
                    cmds_before = gcu_cmds;
                    roms_before = rom_reqs;
                    host_cycle(t_kind[i] == "HR", t_addr[i], t_data[i], t_be[i], rsp, cycles);
                    seen = (gcu_cmds != cmds_before) ? last_op : pipibibs_pkg::GCU_IDLE;
                    exp_rsp.dtack = 1'b1;
                    exp_rsp.rdata = t_exp[i];
                    check_rsp(t_name[i], exp_rsp, rsp);
                    check_op(t_name[i], pipibibs_pkg::gcu_op_t'(t_op[i][2:0]), seen);
                    check_rom_cs(t_name[i], t_addr[i] <= 24'h03FFFF, rom_reqs != roms_before);
                    if (t_cyc[i] != 0)
                        check_cycles(t_name[i], t_cyc[i], cycles);
                end
                "ZW": begin
                    sram_addr = t_addr[i][SRAM_AW-1:0];
                    sram_din  = t_data[i][7:0];
                    sram_we   = 1'b1;
                    @(posedge clk96);
                    #1;
                    sram_we = 1'b0;
                end
                "ZR": begin
                    sram_addr = t_addr[i][SRAM_AW-1:0];
                    @(posedge clk96);
                    #1;
                    check_data(t_name[i], t_exp[i], {8'h00, sram_data});
                end
                "PR": begin
                    palram_addr = t_addr[i][PALRAM_AW-1:0];
                    @(posedge clk96);
                    #1;
                    check_data(t_name[i], t_exp[i], palram_data);
                end
                default: abort_run($sformatf("unknown operation %s in the golden file",
                                             t_kind[i]));
            endcase
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: verif/pipibibs_golden.txt
# name kind addr data be expect gcu_op cycles (cycles 0 = not checked)
# HR/HW host read/write (HR data sets v), ZR/ZW sound port, PR palette port
wram_word_wr  HW 080100 1234 3 0000 0 3
wram_hi_wr    HW 080100 AB99 2 0000 0 3
wram_hi_rd    HR 080100 0000 3 AB34 0 3
wram_lo_wr    HW 080100 77CD 1 0000 0 3
wram_lo_rd    HR 080100 0000 3 ABCD 0 3
pal_wr        HW 0C0040 7C1F 3 0000 0 3
pal_port_rd   PR 000020 0000 0 7C1F 0 0
sram_host_wr  HW 190010 00A7 1 0000 0 3
sram_snd_rd   ZR 000008 0000 0 00A7 0 0
sram_snd_wr   ZW 00000A 005C 1 0000 0 0
sram_host_rd  HR 190014 0000 3 5C5C 0 3
io_in1        HR 19C030 0000 3 2323 0 3
io_in2        HR 19C034 0000 3 7F7F 0 3
io_sys        HR 19C02C 0000 3 964C 0 3
io_dswa       HR 19C020 0000 3 5A5A 0 3
io_dswb       HR 19C024 0000 3 C3C3 0 3
io_jumper     HR 19C028 0000 3 0606 0 3
io_unlisted   HR 19C040 0000 3 0000 0 3
rom_low       HR 000100 0000 3 FF7F 0 0
rom_mid       HR 012344 0000 3 6E5D 0 0
rom_last      HR 03FFFE 0000 3 0000 0 0
gcu_ram_ptr   HW 140000 0100 3 0000 1 0
gcu_sel_reg   HW 140008 0002 3 0000 2 0
gcu_wr_reg    HW 14000C 00FF 3 0000 3 0
gcu_wr_ram_h  HW 140004 1111 3 0000 4 0
gcu_wr_ram_l  HW 140006 2222 3 0000 4 0
gcu_rd_ram_h  HR 140004 0000 3 A505 5 0
gcu_rd_ram_l  HR 140006 0000 3 A506 6 0
gcu_unlisted  HR 140002 0000 3 0000 0 3
vcount_v0     HR 14000C 0000 3 0000 0 3
vcount_v229   HR 14000C 00E5 3 0000 0 3
vcount_v230   HR 14000C 00E6 3 0001 0 3
vcount_v250   HR 14000C 00FA 3 0000 0 3
unmapped      HR 200000 0000 3 0000 0 3

// File: tb.f
verilog/pipibibs_pkg.sv
verilog/pipibibs_addr_dec.sv
verilog/pipibibs_dpram.sv
verilog/pipibibs_io_ports.sv
verilog/pipibibs_gcu_ops.sv
verilog/pipibibs_bus_ctrl.sv
verilog/pipibibs_main.sv
verif/pipibibs_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pipibibs_tb -f tb.f -o pipibibs_sim
./obj_dir/pipibibs_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
